/* bp_host_io.f */
+incdir+test
hw/host_io_pkg.sv
hw/host_putchar_fifo.sv
hw/host_status_bank.sv
hw/host_bus_ctrl.sv
hw/host_io_top.sv
test/tb_host_io.sv

/* hw/host_bus_ctrl.sv */
// ##########################################################
// Host I/O bus controller
// Wishbone classic slave: address decode, legality check,
// registered ack/err and putchar back-pressure
// ##########################################################

`timescale 1ns/1ps

module host_bus_ctrl (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  host_io_pkg::wb_req_s             wb_req_i,
  output host_io_pkg::wb_rsp_s             wb_rsp_o,
  output host_io_pkg::status_op_e          op_o,
  output host_io_pkg::host_wdata_u         wdata_o,
  output logic                             rsel_mask_o,
  input  logic [host_io_pkg::DATA_W-1:0]   rdata_i,
  output logic                             push_o,
  output logic [host_io_pkg::CHAR_W-1:0]   push_char_o,
  input  logic                             fifo_full_i
);
  import host_io_pkg::*;

  status_op_e        dec_op;
  logic              legal;
  logic              is_putchar;
  logic              go;
  logic              done;
  logic              ack_q;
  logic              err_q;
  logic [DATA_W-1:0] dat_q;
  host_wdata_u       wdata;

  // Decode and legality
  always_comb
  begin
    dec_op      = OP_NONE;
    legal       = 1'b0;
    is_putchar  = 1'b0;
    rsel_mask_o = 1'b0;
    case (wb_req_i.adr)
      ADDR_PUTCHAR:
      begin
        legal      = wb_req_i.we;
        is_putchar = wb_req_i.we;
      end
      ADDR_ENABLE:
      begin
        legal  = 1'b1;
        dec_op = wb_req_i.we ? OP_WRITE : OP_NONE;
      end
      ADDR_ENABLE_SET:
      begin
        legal  = wb_req_i.we;
        dec_op = OP_SET;
      end
      ADDR_ENABLE_CLR:
      begin
        legal  = wb_req_i.we;
        dec_op = OP_CLEAR;
      end
      ADDR_FINISH:
      begin
        // Hart id must be in range
        legal  = wb_req_i.we && (wb_req_i.dat < DATA_W'(NUM_HARTS));
        dec_op = OP_FINISH;
      end
      ADDR_FINISH_MASK:
      begin
        legal       = !wb_req_i.we;
        rsel_mask_o = 1'b1;
      end
      default: legal = 1'b0;
    endcase
  end

  // New request only outside the guard cycle after a response
  assign go   = wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;
  // Putchar waits here while the buffer is full
  assign done = go && legal && !(is_putchar && fifo_full_i);

  assign wdata.raw   = wb_req_i.dat;
  assign wdata_o     = wdata;
  assign op_o        = (go && legal) ? dec_op : OP_NONE;
  assign push_o      = done && is_putchar;
  assign push_char_o = wdata.raw[CHAR_W-1:0];

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= done;
      err_q <= go && !legal;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (go)
      dat_q <= (legal && !wb_req_i.we) ? rdata_i : '0;
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.err = err_q;
  assign wb_rsp_o.dat = dat_q;

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(wb_rsp_o.ack && wb_rsp_o.err));

  a_no_issue_in_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_rsp_o.ack |-> (op_o == OP_NONE) && !push_o);

endmodule

/* hw/host_io_pkg.sv */
// ##########################################################
// Host I/O package
// Address map, widths and the bus, enable and write-word
// types shared by the host I/O device
// ##########################################################

package host_io_pkg;

  localparam int DATA_W     = 32;
  localparam int ADDR_W     = 4;
  localparam int NUM_HARTS  = 4;
  localparam int HART_ID_W  = 2;
  localparam int CHAR_W     = 8;
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);

  // Word address map
  localparam logic [ADDR_W-1:0] ADDR_PUTCHAR     = 4'd0;
  localparam logic [ADDR_W-1:0] ADDR_ENABLE      = 4'd1;
  localparam logic [ADDR_W-1:0] ADDR_ENABLE_SET  = 4'd2;
  localparam logic [ADDR_W-1:0] ADDR_ENABLE_CLR  = 4'd3;
  localparam logic [ADDR_W-1:0] ADDR_FINISH      = 4'd4;
  localparam logic [ADDR_W-1:0] ADDR_FINISH_MASK = 4'd5;

  typedef struct packed {
    logic cosim;
    logic branch_profile;
    logic pc_profile;
    logic core_profile;
    logic cmt;
    logic vm;
    logic dram;
    logic cce;
    logic lce;
    logic dcache;
    logic icache;
  } trace_en_s;

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
  } wb_req_s;

  typedef struct packed {
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] dat;
  } wb_rsp_s;

  // Bus write word, seen raw or as an enable set
  typedef union packed {
    logic [DATA_W-1:0] raw;
    struct packed {
      logic [DATA_W-$bits(trace_en_s)-1:0] pad;
      trace_en_s                           en;
    } en_view;
  } host_wdata_u;

  typedef enum logic [2:0] {
    OP_NONE,
    OP_WRITE,
    OP_SET,
    OP_CLEAR,
    OP_FINISH
  } status_op_e;

endpackage

/* hw/host_io_top.sv */
// ##########################################################
// Host I/O device top level
// Wishbone slave with putchar stream, trace enables and
// per-hart finish flags
// ##########################################################

`timescale 1ns/1ps

module host_io_top (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  host_io_pkg::wb_req_s             wb_req_i,
  output host_io_pkg::wb_rsp_s             wb_rsp_o,
  output logic [host_io_pkg::CHAR_W-1:0]   char_o,
  output logic                             char_valid_o,
  input  logic                             char_ready_i,
  output host_io_pkg::trace_en_s           trace_en_o,
  output logic                             all_finished_o
);
  import host_io_pkg::*;

  status_op_e          op;
  host_wdata_u         wdata;
  logic                rsel_mask;
  logic [DATA_W-1:0]   rdata;
  logic                push;
  logic [CHAR_W-1:0]   push_char;
  logic                fifo_full;

  host_bus_ctrl u_bus_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .wb_req_i    (wb_req_i),
    .wb_rsp_o    (wb_rsp_o),
    .op_o        (op),
    .wdata_o     (wdata),
    .rsel_mask_o (rsel_mask),
    .rdata_i     (rdata),
    .push_o      (push),
    .push_char_o (push_char),
    .fifo_full_i (fifo_full)
  );

  host_status_bank u_status_bank (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .op_i           (op),
    .wdata_i        (wdata),
    .rsel_mask_i    (rsel_mask),
    .rdata_o        (rdata),
    .trace_en_o     (trace_en_o),
    .all_finished_o (all_finished_o)
  );

  host_putchar_fifo u_putchar_fifo (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (push),
    .char_i       (push_char),
    .full_o       (fifo_full),
    .char_o       (char_o),
    .char_valid_o (char_valid_o),
    .char_ready_i (char_ready_i)
  );

endmodule

/* hw/host_putchar_fifo.sv */
// ##########################################################
// Putchar character buffer
// Circular FIFO feeding the ready/valid character output
// ##########################################################

`timescale 1ns/1ps

module host_putchar_fifo (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  logic                             push_i,
  input  logic [host_io_pkg::CHAR_W-1:0]   char_i,
  output logic                             full_o,
  output logic [host_io_pkg::CHAR_W-1:0]   char_o,
  output logic                             char_valid_o,
  input  logic                             char_ready_i
);
  import host_io_pkg::*;

  logic [CHAR_W-1:0]     mem_q [FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0] wr_ptr_q;
  logic [FIFO_PTR_W-1:0] rd_ptr_q;
  logic [FIFO_PTR_W:0]   count_q;
  logic                  pop;

  assign pop = char_valid_o && char_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (push_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous push and pop keeps the count
      if (push_i && !pop)
        count_q <= count_q + 1'b1;
      else if (pop && !push_i)
        count_q <= count_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (push_i)
      mem_q[wr_ptr_q] <= char_i;
  end

  assign full_o       = (count_q == (FIFO_PTR_W+1)'(FIFO_DEPTH));
  assign char_valid_o = (count_q != '0);
  assign char_o       = mem_q[rd_ptr_q];

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o);

endmodule

/* hw/host_status_bank.sv */
// ##########################################################
// Host I/O status bank
// Trace enable register, sticky per-hart finish mask and
// the read data mux
// ##########################################################

`timescale 1ns/1ps

module host_status_bank (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  host_io_pkg::status_op_e          op_i,
  input  host_io_pkg::host_wdata_u         wdata_i,
  input  logic                             rsel_mask_i,
  output logic [host_io_pkg::DATA_W-1:0]   rdata_o,
  output host_io_pkg::trace_en_s           trace_en_o,
  output logic                             all_finished_o
);
  import host_io_pkg::*;

  trace_en_s              en_q;
  trace_en_s              en_wr;
  logic [NUM_HARTS-1:0]   fin_q;
  logic [HART_ID_W-1:0]   hart_id;

  assign en_wr   = wdata_i.en_view.en;
  assign hart_id = wdata_i.raw[HART_ID_W-1:0];

  // Enable register
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      en_q <= '0;
    end
    else
    begin
      case (op_i)
        OP_WRITE: en_q <= en_wr;
        OP_SET:   en_q <= trace_en_s'(en_q | en_wr);
        OP_CLEAR: en_q <= trace_en_s'(en_q & ~en_wr);
        default:  en_q <= en_q;
      endcase
    end
  end

  // Finish bits stay set until reset
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      fin_q <= '0;
    end
    else if (op_i == OP_FINISH)
    begin
      fin_q[hart_id] <= 1'b1;
    end
  end

  assign trace_en_o     = en_q;
  assign all_finished_o = &fin_q;

  // Read data, zero padded
  always_comb
  begin
    if (rsel_mask_i)
      rdata_o = DATA_W'(fin_q);
    else
      rdata_o = DATA_W'(en_q);
  end

  a_fin_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (fin_q & $past(fin_q)) == $past(fin_q));

endmodule

/* run.sh */
#!/bin/sh
# Build and run the host I/O testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_host_io \
  -f bp_host_io.f -o sim_host_io \
  || { echo "Build failed"; exit 1; }
out="$(./obj_dir/sim_host_io)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL TESTS PASSED" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

/* test/tb_host_io_props.svh */
// ##########################################################
// Host I/O testbench checks
// Error counters and the concurrent assertions that compare
// the DUT with the reference model
// ##########################################################

int check_errors   = 0;
int timeout_errors = 0;

a_reset_quiet: assert property (@(posedge clk)
  (rst_seen && !rst_d) |->
  ({rsp.ack, rsp.err, char_valid, trace_en, all_finished} == '0))
  else
  begin
    check_errors++;
    $display("[FAIL] reset outputs ack,err,valid,trace_en,all_finished = %h, expected 0",
             $sampled({rsp.ack, rsp.err, char_valid, trace_en, all_finished}));
  end

a_trace_en: assert property (@(posedge clk) disable iff (!rst_n)
  trace_en == model_en)
  else
  begin
    check_errors++;
    $display("[FAIL] trace_en_o = %h, expected %h", $sampled(trace_en), $sampled(model_en));
  end

a_all_finished: assert property (@(posedge clk) disable iff (!rst_n)
  all_finished == (&model_fin))
  else
  begin
    check_errors++;
    $display("[FAIL] all_finished_o = %h, expected %h",
             $sampled(all_finished), $sampled(&model_fin));
  end

// Anything but putchar answers in the next cycle
a_ack_latency: assert property (@(posedge clk) disable iff (!rst_n)
  (req.cyc && req.stb && !rsp.ack && !rsp.err && !(req.we && req.adr == ADDR_PUTCHAR))
  |=> (rsp.ack || rsp.err))
  else
  begin
    check_errors++;
    $display("No bus response in the cycle after a request was sampled");
  end

a_resp_kind: assert property (@(posedge clk) disable iff (!rst_n)
  (rsp.ack || rsp.err) |-> (rsp.err == expect_err))
  else
  begin
    check_errors++;
    $display("[FAIL] wb_rsp_o.err = %h, expected %h", $sampled(rsp.err), $sampled(expect_err));
  end

a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
  (rsp.ack && check_rd) |-> (rsp.dat == rd_expect))
  else
  begin
    check_errors++;
    $display("[FAIL] wb_rsp_o.dat = %h, expected %h", $sampled(rsp.dat), $sampled(rd_expect));
  end

a_char_order: assert property (@(posedge clk) disable iff (!rst_n)
  (char_valid && char_ready) |-> (char_data == exp_chars[exp_rd]))
  else
  begin
    check_errors++;
    $display("[FAIL] char_o = %h, expected %h",
             $sampled(char_data), $sampled(exp_chars[exp_rd]));
  end

a_char_expected: assert property (@(posedge clk) disable iff (!rst_n)
  char_valid |-> (exp_rd != exp_wr))
  else
  begin
    check_errors++;
    $display("Character output valid with no character written");
  end

// Four characters waiting, so a putchar must stall
a_putchar_stall: assert property (@(posedge clk) disable iff (!rst_n)
  (req.cyc && req.stb && req.we && req.adr == ADDR_PUTCHAR &&
   5'(exp_wr - exp_rd) >= 5'(FIFO_DEPTH)) |=> !rsp.ack)
  else
  begin
    check_errors++;
    $display("Putchar acknowledged while the character buffer was full");
  end

/* test/tb_host_io.sv */
// ##########################################################
// Host I/O testbench
// Wishbone master, character sink and reference model for
// the host I/O device
// ##########################################################

`timescale 1ns/1ps

module tb_host_io;
  import host_io_pkg::*;

  localparam int WAIT_MAX = 100;
  localparam int EN_W     = $bits(trace_en_s);

  logic                 clk = 1'b0;
  logic                 rst_n;
  wb_req_s              req;
  wb_rsp_s              rsp;
  logic [CHAR_W-1:0]    char_data;
  logic                 char_valid;
  logic                 char_ready;
  trace_en_s            trace_en;
  logic                 all_finished;

  // Reference model and expectations for the current request
  logic [EN_W-1:0]      model_en = '0;
  logic [NUM_HARTS-1:0] model_fin = '0;
  logic [CHAR_W-1:0]    exp_chars [32];
  logic [4:0]           exp_wr = '0;
  logic [4:0]           exp_rd = '0;
  logic                 expect_err = 1'b0;
  logic                 check_rd = 1'b0;
  logic [DATA_W-1:0]    rd_expect = '0;
  logic                 rst_d = 1'b0;
  logic                 rst_seen = 1'b0;
  logic                 rand_ready = 1'b0;
  int                   seed;
  int                   hart_order [5] = '{2, 0, 2, 3, 1};

  `include "tb_host_io_props.svh"

  host_io_top u_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .wb_req_i       (req),
    .wb_rsp_o       (rsp),
    .char_o         (char_data),
    .char_valid_o   (char_valid),
    .char_ready_i   (char_ready),
    .trace_en_o     (trace_en),
    .all_finished_o (all_finished)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    rst_d <= rst_n;
    if (!rst_n)
      rst_seen <= 1'b1;
    if (rst_n && char_valid && char_ready)
      exp_rd <= exp_rd + 1'b1;
  end

  always @(negedge clk)
  begin
    if (rand_ready)
      char_ready = 1'($random(seed));
  end

  function automatic logic is_illegal(input logic we, input logic [ADDR_W-1:0] adr,
                                      input logic [DATA_W-1:0] dat);
    case (adr)
      ADDR_PUTCHAR, ADDR_ENABLE_SET, ADDR_ENABLE_CLR: return !we;
      ADDR_ENABLE:      return 1'b0;
      ADDR_FINISH:      return !we || (dat >= NUM_HARTS);
      ADDR_FINISH_MASK: return we;
      default:          return 1'b1;
    endcase
  endfunction

  task automatic bus_start(input logic we, input logic [ADDR_W-1:0] adr,
                           input logic [DATA_W-1:0] dat);
    req.cyc    = 1'b1;
    req.stb    = 1'b1;
    req.we     = we;
    req.adr    = adr;
    req.dat    = dat;
    expect_err = is_illegal(we, adr, dat);
    check_rd   = !we && !expect_err;
    rd_expect  = (adr == ADDR_FINISH_MASK) ? DATA_W'(model_fin) : DATA_W'(model_en);
    if (we && adr == ADDR_PUTCHAR)
      exp_chars[exp_wr] = dat[CHAR_W-1:0];
  endtask

  // Wait for ack or err, commit the model, release the bus
  task automatic bus_finish();
    int n;
    n = 0;
    while (!rsp.ack && !rsp.err && n < WAIT_MAX)
    begin
      @(negedge clk);
      n++;
    end
    if (rsp.ack && req.we)
    begin
      case (req.adr)
        ADDR_PUTCHAR:    exp_wr = exp_wr + 1'b1;
        ADDR_ENABLE:     model_en = req.dat[EN_W-1:0];
        ADDR_ENABLE_SET: model_en = model_en | req.dat[EN_W-1:0];
        ADDR_ENABLE_CLR: model_en = model_en & ~req.dat[EN_W-1:0];
        ADDR_FINISH:     model_fin[req.dat[HART_ID_W-1:0]] = 1'b1;
        default:         ;
      endcase
    end
    else if (!rsp.ack && !rsp.err)
    begin
      timeout_errors++;
      $display("Timeout waiting for a bus response at address %h", req.adr);
    end
    req.cyc = 1'b0;
    req.stb = 1'b0;
    @(negedge clk);
    expect_err = 1'b0;
    check_rd   = 1'b0;
  endtask

  task automatic bus_xfer(input logic we, input logic [ADDR_W-1:0] adr,
                          input logic [DATA_W-1:0] dat);
    bus_start(we, adr, dat);
    bus_finish();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_rd != exp_wr && n < WAIT_MAX)
    begin
      @(negedge clk);
      n++;
    end
    if (exp_rd != exp_wr)
    begin
      timeout_errors++;
      $display("Timeout waiting for characters on char_o");
    end
  endtask

  initial
  begin
    seed       = 7752;
    rst_n      = 1'b0;
    req        = '0;
    char_ready = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    bus_xfer(1'b0, ADDR_FINISH_MASK, '0);

    // Random enable writes, sets and clears with read-back
    repeat (12)
    begin
      bus_xfer(1'b1, ADDR_ENABLE + ADDR_W'({$random(seed)} % 3), $random(seed));
      bus_xfer(1'b0, ADDR_ENABLE, '0);
    end

    rand_ready = 1'b1;
    repeat (10)
      bus_xfer(1'b1, ADDR_PUTCHAR, $random(seed));
    wait_drain();

    // Ready low fills the buffer, the fifth write stalls
    rand_ready = 1'b0;
    char_ready = 1'b0;
    repeat (4)
      bus_xfer(1'b1, ADDR_PUTCHAR, $random(seed));
    bus_start(1'b1, ADDR_PUTCHAR, $random(seed));
    repeat (8) @(negedge clk);
    char_ready = 1'b1;
    bus_finish();
    wait_drain();

    bus_xfer(1'b0, 4'd9, '0);
    bus_xfer(1'b1, 4'd14, 32'h7ff);
    bus_xfer(1'b1, ADDR_FINISH_MASK, 32'hf);
    bus_xfer(1'b0, ADDR_PUTCHAR, '0);
    bus_xfer(1'b1, ADDR_FINISH, 32'd4);
    bus_xfer(1'b0, ADDR_ENABLE, '0);
    bus_xfer(1'b0, ADDR_FINISH_MASK, '0);

    foreach (hart_order[i])
    begin
      bus_xfer(1'b1, ADDR_FINISH, DATA_W'(hart_order[i]));
      bus_xfer(1'b0, ADDR_FINISH_MASK, '0);
    end

    repeat (2) @(negedge clk);
    $display("Errors: %0d check, %0d timeout", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
